//--- vlog.f
design/nlc_pkg.sv
design/nlc_param_bank.sv
design/nlc_channel_sequencer.sv
design/nlc_normalize_stage.sv
design/nlc_horner_step.sv
design/nlc_output_stage.sv
design/nlc_top.sv
verification/nlc_clock_gen.sv
verification/nlc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the nlc testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module nlc_tb -f vlog.f -o nlc_sim \
	&& ./obj_dir/nlc_sim \
	|| { echo "simulation failed"; exit 1; }

//--- verification/nlc_tb.sv
`default_nettype none

module nlc_tb;
	import nlc_pkg::*;

	typedef sample_t [NUM_CH-1:0] sample_vec_t;

	localparam fix_t ONE = fix_t'(1 <<< FRAC_BITS);
	localparam fix_t BIG = fix_t'(100 <<< FRAC_BITS);
	localparam int CLAMP_HI = (1 <<< (SAMPLE_W - 1)) - 1;
	localparam int CLAMP_LO = -(1 <<< (SAMPLE_W - 1));
	localparam int WAIT_LIMIT = 80;

	logic clk;
	logic rst;
	logic start;
	sample_vec_t x_adc;
	cfg_write_t cfg;
	sample_vec_t x_lin;
	logic out_valid;
	logic [CH_W-1:0] out_ch;
	logic done;

	int seed = 13;
	int cyc = 0;
	int done_seen = 0;
	chan_params_t tb_params [NUM_CH];

	// Expected results in the order the channels come out
	logic [CH_W-1:0] exp_ch [$];
	sample_t exp_val [$];
	int exp_cyc [$];
	logic exp_last [$];

	logic [CH_W-1:0] ch_e;
	sample_t val_e;
	int cyc_e;
	logic last_e;

	chan_params_t p;
	sample_vec_t s;
	sample_vec_t s2;

	nlc_clock_gen u_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	nlc_top u_nlc_top (
		.clk(clk),
		.rst(rst),
		.start(start),
		.x_adc(x_adc),
		.cfg(cfg),
		.x_lin(x_lin),
		.out_valid(out_valid),
		.out_ch(out_ch),
		.done(done)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic stop_with_error(input string why);
		$display("ERROR at time %0t: %s", $time, why);
		$display("** FAIL **");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED at time %0t: %s = 0x%h, expected 0x%h",
				$time, name, got, expected);
			$display("** FAIL **");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Full signed product, shift right by the fraction bits, keep 32 bits
	function automatic fix_t fixed_mul(input fix_t a, input fix_t b);
		logic signed [63:0] wide;
		wide = 64'(a) * 64'(b);
		return wide[47:16];
	endfunction

	function automatic sample_t expected_result(input sample_t smp, input chan_params_t prm);
		fix_t x;
		fix_t acc;
		x = fixed_mul(fix_t'(smp) + prm.neg_mean, prm.recip_stdev);
		acc = prm.coeffs[5];
		for (int i = 4; i >= 0; i--) begin
			acc = fixed_mul(acc, x) + prm.coeffs[i];
		end
		if (acc > CLAMP_HI) begin
			return sample_t'(CLAMP_HI);
		end else if (acc < CLAMP_LO) begin
			return sample_t'(CLAMP_LO);
		end else begin
			return acc[SAMPLE_W-1:0];
		end
	endfunction

	task automatic write_word(input int ch, input param_sel_e sel, input fix_t data);
		@(posedge clk);
		cfg.we <= 1'b1;
		cfg.ch <= ch[CH_W-1:0];
		cfg.sel <= sel;
		cfg.data <= data;
	endtask

	task automatic load_channel(input int ch, input chan_params_t prm);
		write_word(ch, SEL_NEG_MEAN, prm.neg_mean);
		write_word(ch, SEL_RECIP_STDEV, prm.recip_stdev);
		write_word(ch, SEL_COEFF_0, prm.coeffs[0]);
		write_word(ch, SEL_COEFF_1, prm.coeffs[1]);
		write_word(ch, SEL_COEFF_2, prm.coeffs[2]);
		write_word(ch, SEL_COEFF_3, prm.coeffs[3]);
		write_word(ch, SEL_COEFF_4, prm.coeffs[4]);
		write_word(ch, SEL_COEFF_5, prm.coeffs[5]);
		@(posedge clk);
		cfg.we <= 1'b0;
		tb_params[ch] = prm;
	endtask

	task automatic random_params(output chan_params_t prm);
		int i;
		prm.neg_mean = fix_t'($random(seed) >>> 12);
		// Scale below 1/16 keeps x small enough to mix clamped and unclamped results
		prm.recip_stdev = fix_t'($random(seed) & 32'h0000_0fff);
		for (i = 0; i <= POLY_ORDER; i++) begin
			prm.coeffs[i] = fix_t'($random(seed) >>> 16);
		end
	endtask

	task automatic random_samples(output sample_vec_t smp);
		int k;
		for (k = 0; k < NUM_CH; k++) begin
			smp[k] = sample_t'($random(seed));
		end
	endtask

	// Call on a rising edge; start is seen by the DUT on the next one
	task automatic start_sweep(input sample_vec_t smp);
		int e0;
		int k;
		start <= 1'b1;
		x_adc <= smp;
		// cyc has not counted this edge yet
		e0 = cyc + 2;
		for (k = 0; k < NUM_CH; k++) begin
			exp_ch.push_back(k[CH_W-1:0]);
			exp_val.push_back(expected_result(smp[k], tb_params[k]));
			exp_cyc.push_back(e0 + 8 + k);
			exp_last.push_back(k == NUM_CH - 1);
		end
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Start that the sequencer must ignore
	task automatic stray_start(input sample_vec_t smp);
		start <= 1'b1;
		x_adc <= smp;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_reset_release();
		int i;
		for (i = 0; i < WAIT_LIMIT && rst; i++) begin
			@(posedge clk);
		end
		if (rst) begin
			stop_with_error("reset was never released");
		end
	endtask

	task automatic wait_for_done(input int target);
		int i;
		for (i = 0; i < WAIT_LIMIT && done_seen < target; i++) begin
			@(posedge clk);
		end
		if (done_seen < target) begin
			stop_with_error("timed out waiting for done");
		end
	endtask

	task automatic check_idle_outputs(input int cycles);
		int i;
		int k;
		for (i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_value("out_valid", 32'(out_valid), 32'h0);
			check_value("done", 32'(done), 32'h0);
			for (k = 0; k < NUM_CH; k++) begin
				check_value($sformatf("x_lin[%0d]", k), 32'(x_lin[k]), 32'h0);
			end
		end
	endtask

	// Compare every result as it leaves the pipeline
	always @(negedge clk) begin
		if (!rst) begin
			if (out_valid && exp_ch.size() == 0) begin
				stop_with_error("out_valid was raised with no result pending");
			end else if (out_valid) begin
				ch_e = exp_ch.pop_front();
				val_e = exp_val.pop_front();
				cyc_e = exp_cyc.pop_front();
				last_e = exp_last.pop_front();
				check_value("out_ch", 32'(out_ch), 32'(ch_e));
				check_value("x_lin[out_ch]", 32'(x_lin[out_ch]), 32'(val_e));
				check_value("out_valid cycle", cyc, cyc_e);
				check_value("done", 32'(done), 32'(last_e));
				if (done) begin
					done_seen = done_seen + 1;
				end
			end else begin
				check_value("done", 32'(done), 32'h0);
			end
		end
	end

	initial begin
		start <= 1'b0;
		x_adc <= '0;
		cfg <= '0;

		wait_reset_release();
		check_idle_outputs(20);

		// Identity polynomial
		for (int ch = 0; ch < NUM_CH; ch++) begin
			p = '0;
			p.recip_stdev = ONE;
			p.coeffs[1] = ONE;
			load_channel(ch, p);
		end
		random_samples(s);
		@(posedge clk);
		start_sweep(s);
		wait_for_done(1);
		@(negedge clk);
		for (int k = 0; k < NUM_CH; k++) begin
			check_value($sformatf("x_lin[%0d]", k), 32'(x_lin[k]), 32'(s[k]));
		end

		// Even channels clamp high, odd ones low
		for (int ch = 0; ch < NUM_CH; ch++) begin
			p = '0;
			p.recip_stdev = ONE;
			p.coeffs[1] = ONE;
			p.coeffs[0] = (ch % 2 == 0) ? BIG : -BIG;
			load_channel(ch, p);
		end
		random_samples(s);
		@(posedge clk);
		start_sweep(s);
		wait_for_done(2);
		@(negedge clk);
		for (int k = 0; k < NUM_CH; k++) begin
			check_value($sformatf("x_lin[%0d]", k), 32'(x_lin[k]),
				(k % 2 == 0) ? CLAMP_HI : CLAMP_LO);
		end

		// Random parameters and samples
		for (int ch = 0; ch < NUM_CH; ch++) begin
			random_params(p);
			load_channel(ch, p);
		end
		random_samples(s);
		@(posedge clk);
		start_sweep(s);
		wait_for_done(3);

		// Start during issue is dropped
		random_samples(s);
		random_samples(s2);
		@(posedge clk);
		start_sweep(s);
		repeat (4) @(posedge clk);
		stray_start(s2);
		wait_for_done(4);
		repeat (30) @(posedge clk);

		// Second start lands on E16 and the sweeps overlap
		random_samples(s);
		random_samples(s2);
		@(posedge clk);
		start_sweep(s);
		repeat (15) @(posedge clk);
		start_sweep(s2);
		wait_for_done(6);
		repeat (20) @(posedge clk);

		if (exp_ch.size() == 0 && done_seen == 6) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_with_error("results or done pulses missing at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- verification/nlc_clock_gen.sv
`default_nettype none

module nlc_clock_gen (
	output logic clk,
	output logic rst
);
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- design/nlc_top.sv
`default_nettype none

module nlc_top (
	input wire clk,
	input wire rst,
	input wire start,
	input wire nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_adc,
	input wire nlc_pkg::cfg_write_t cfg,
	output nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_lin,
	output logic out_valid,
	output logic [nlc_pkg::CH_W-1:0] out_ch,
	output logic done
);
	import nlc_pkg::*;

	logic [CH_W-1:0] rd_ch;
	chan_params_t rd_params;
	nlc_item_t seq_item;
	nlc_item_t norm_item;
	nlc_item_t step4_item;
	nlc_item_t step3_item;
	nlc_item_t step2_item;
	nlc_item_t step1_item;
	nlc_item_t step0_item;

	nlc_param_bank u_param_bank (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.rd_ch(rd_ch),
		.rd_params(rd_params)
	);

	nlc_channel_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.x_adc(x_adc),
		.rd_ch(rd_ch),
		.rd_params(rd_params),
		.item(seq_item)
	);

	nlc_normalize_stage u_normalize (
		.clk(clk),
		.rst(rst),
		.in_item(seq_item),
		.out_item(norm_item)
	);

	// Each step takes its coefficient from the item it is working on
	nlc_horner_step u_step4 (
		.clk(clk),
		.rst(rst),
		.coeff(norm_item.params.coeffs[4]),
		.in_item(norm_item),
		.out_item(step4_item)
	);

	nlc_horner_step u_step3 (
		.clk(clk),
		.rst(rst),
		.coeff(step4_item.params.coeffs[3]),
		.in_item(step4_item),
		.out_item(step3_item)
	);

	nlc_horner_step u_step2 (
		.clk(clk),
		.rst(rst),
		.coeff(step3_item.params.coeffs[2]),
		.in_item(step3_item),
		.out_item(step2_item)
	);

	nlc_horner_step u_step1 (
		.clk(clk),
		.rst(rst),
		.coeff(step2_item.params.coeffs[1]),
		.in_item(step2_item),
		.out_item(step1_item)
	);

	nlc_horner_step u_step0 (
		.clk(clk),
		.rst(rst),
		.coeff(step1_item.params.coeffs[0]),
		.in_item(step1_item),
		.out_item(step0_item)
	);

	nlc_output_stage u_output (
		.clk(clk),
		.rst(rst),
		.in_item(step0_item),
		.x_lin(x_lin),
		.out_valid(out_valid),
		.out_ch(out_ch),
		.done(done)
	);

endmodule

`default_nettype wire

//--- design/nlc_output_stage.sv
`default_nettype none

module nlc_output_stage (
	input wire clk,
	input wire rst,
	input wire nlc_pkg::nlc_item_t in_item,
	output nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_lin,
	output logic out_valid,
	output logic [nlc_pkg::CH_W-1:0] out_ch,
	output logic done
);
	import nlc_pkg::*;

	sample_t sat_val;

	// Clamp to the signed 21-bit range
	always_comb begin
		if (in_item.acc > fix_t'(SAT_MAX)) begin
			sat_val = SAT_MAX;
		end else if (in_item.acc < fix_t'(SAT_MIN)) begin
			sat_val = SAT_MIN;
		end else begin
			sat_val = in_item.acc[SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_lin <= '0;
			out_valid <= 1'b0;
			out_ch <= '0;
			done <= 1'b0;
		end else begin
			out_valid <= in_item.valid;
			done <= in_item.valid && in_item.last;
			if (in_item.valid) begin
				x_lin[in_item.ch] <= sat_val;
				out_ch <= in_item.ch;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/nlc_horner_step.sv
`default_nettype none

module nlc_horner_step (
	input wire clk,
	input wire rst,
	input wire nlc_pkg::fix_t coeff,
	input wire nlc_pkg::nlc_item_t in_item,
	output nlc_pkg::nlc_item_t out_item
);
	import nlc_pkg::*;

	fix_t next_acc;

	// acc*x + c, add wraps at 32 bits
	assign next_acc = fix_mul(in_item.acc, in_item.x) + coeff;

	always_ff @(posedge clk) begin
		out_item.ch <= in_item.ch;
		out_item.last <= in_item.last;
		out_item.x <= in_item.x;
		out_item.acc <= next_acc;
		out_item.params <= in_item.params;
		if (rst) begin
			out_item.valid <= 1'b0;
		end else begin
			out_item.valid <= in_item.valid;
		end
	end

endmodule

`default_nettype wire

//--- design/nlc_normalize_stage.sv
`default_nettype none

module nlc_normalize_stage (
	input wire clk,
	input wire rst,
	input wire nlc_pkg::nlc_item_t in_item,
	output nlc_pkg::nlc_item_t out_item
);
	import nlc_pkg::*;

	fix_t centered;
	fix_t norm_x;

	assign centered = in_item.x + in_item.params.neg_mean;
	assign norm_x = fix_mul(centered, in_item.params.recip_stdev);

	always_ff @(posedge clk) begin
		out_item.ch <= in_item.ch;
		out_item.last <= in_item.last;
		out_item.x <= norm_x;
		// Horner starts from the top coefficient
		out_item.acc <= in_item.params.coeffs[POLY_ORDER];
		out_item.params <= in_item.params;
		if (rst) begin
			out_item.valid <= 1'b0;
		end else begin
			out_item.valid <= in_item.valid;
		end
	end

endmodule

`default_nettype wire

//--- design/nlc_channel_sequencer.sv
`default_nettype none

module nlc_channel_sequencer (
	input wire clk,
	input wire rst,
	input wire start,
	input wire nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_adc,
	output logic [nlc_pkg::CH_W-1:0] rd_ch,
	input wire nlc_pkg::chan_params_t rd_params,
	output nlc_pkg::nlc_item_t item
);
	import nlc_pkg::*;

	seq_state_e state;
	logic [CH_W-1:0] cnt;
	sample_t [NUM_CH-1:0] samples;
	sample_t cur_sample;
	logic issue;
	logic last_ch;
	logic accept;

	assign issue = (state == SEQ_ISSUE);
	assign last_ch = (cnt == CH_W'(NUM_CH - 1));
	// Restart allowed on the edge that issues channel 15
	assign accept = start && (!issue || last_ch);
	assign cur_sample = samples[cnt];
	assign rd_ch = cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEQ_IDLE;
			cnt <= '0;
		end else if (accept) begin
			state <= SEQ_ISSUE;
			cnt <= '0;
		end else if (issue) begin
			cnt <= cnt + 1'b1;
			if (last_ch) begin
				state <= SEQ_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			samples <= x_adc;
		end
	end

	always_ff @(posedge clk) begin
		item.ch <= cnt;
		item.last <= last_ch;
		item.x <= {{(DATA_W-SAMPLE_W){cur_sample[SAMPLE_W-1]}}, cur_sample};
		item.acc <= '0;
		item.params <= rd_params;
		if (rst) begin
			item.valid <= 1'b0;
		end else begin
			item.valid <= issue;
		end
	end

endmodule

`default_nettype wire

//--- design/nlc_param_bank.sv
`default_nettype none

module nlc_param_bank (
	input wire clk,
	input wire rst,
	input wire nlc_pkg::cfg_write_t cfg,
	input wire [nlc_pkg::CH_W-1:0] rd_ch,
	output nlc_pkg::chan_params_t rd_params
);
	import nlc_pkg::*;

	chan_params_t bank [NUM_CH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CH; i++) begin
				bank[i] <= '0;
			end
		end else if (cfg.we) begin
			case (cfg.sel)
				SEL_NEG_MEAN: bank[cfg.ch].neg_mean <= cfg.data;
				SEL_RECIP_STDEV: bank[cfg.ch].recip_stdev <= cfg.data;
				SEL_COEFF_0: bank[cfg.ch].coeffs[0] <= cfg.data;
				SEL_COEFF_1: bank[cfg.ch].coeffs[1] <= cfg.data;
				SEL_COEFF_2: bank[cfg.ch].coeffs[2] <= cfg.data;
				SEL_COEFF_3: bank[cfg.ch].coeffs[3] <= cfg.data;
				SEL_COEFF_4: bank[cfg.ch].coeffs[4] <= cfg.data;
				SEL_COEFF_5: bank[cfg.ch].coeffs[5] <= cfg.data;
				default: ;
			endcase
		end
	end

	// Read is combinational, sequencer registers it
	assign rd_params = bank[rd_ch];

endmodule

`default_nettype wire

//--- design/nlc_pkg.sv
`default_nettype none

package nlc_pkg;

	localparam int NUM_CH = 16;
	localparam int CH_W = 4;
	localparam int SAMPLE_W = 21;
	localparam int DATA_W = 32;
	localparam int FRAC_BITS = 16;
	localparam int POLY_ORDER = 5;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [DATA_W-1:0] fix_t;

	localparam sample_t SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

	// Word select for the config write port
	typedef enum logic [2:0] {
		SEL_NEG_MEAN,
		SEL_RECIP_STDEV,
		SEL_COEFF_0,
		SEL_COEFF_1,
		SEL_COEFF_2,
		SEL_COEFF_3,
		SEL_COEFF_4,
		SEL_COEFF_5
	} param_sel_e;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_ISSUE
	} seq_state_e;

	typedef struct packed {
		fix_t neg_mean;
		fix_t recip_stdev;
		fix_t [POLY_ORDER:0] coeffs;
	} chan_params_t;

	typedef struct packed {
		logic we;
		logic [CH_W-1:0] ch;
		param_sel_e sel;
		fix_t data;
	} cfg_write_t;

	// One channel in flight through the pipeline
	typedef struct packed {
		logic valid;
		logic [CH_W-1:0] ch;
		logic last;
		fix_t x;
		fix_t acc;
		chan_params_t params;
	} nlc_item_t;

	// Q15.16 multiply, full product then back to 32 bits
	function automatic fix_t fix_mul(fix_t a, fix_t b);
		logic signed [2*DATA_W-1:0] prod;
		prod = a * b;
		return fix_t'(prod >>> FRAC_BITS);
	endfunction

endpackage

`default_nettype wire
